// File: hw/fpsu_config.svh
`ifndef FPSU_CONFIG_SVH
`define FPSU_CONFIG_SVH

// Width of one SIMD half of an operand
`define FPSU_HALF_W 68

// Issue ports served by the unit
`define FPSU_NUM_PORTS 2

// Forwarding buses an operand can be taken from
`define FPSU_FWD_SRCS 4

// Tag carried from issue to retire
`define FPSU_TAG_W 6

`endif

// File: hw/fpsu_op_pkg.sv
package fpsu_op_pkg;

  // Opcodes accepted on an issue port
  typedef enum logic [2:0] {
    op_and    = 3'd0,
    op_or     = 3'd1,
    op_xor    = 3'd2,
    op_andn   = 3'd3,
    op_mov    = 3'd4,
    op_swap   = 3'd5,
    op_dup_lo = 3'd6,
    op_dup_hi = 3'd7
  } fpsu_op_e;

  // Function applied by one half in stage 2
  typedef enum logic [2:0] {
    fn_and  = 3'd0,
    fn_or   = 3'd1,
    fn_xor  = 3'd2,
    fn_andn = 3'd3,
    fn_pass = 3'd4
  } fpsu_func_e;

  // Decoded control for one half of one port
  typedef struct packed {
    fpsu_func_e func;
    logic       use_other;
    logic       valid;
  } fpsu_half_ctrl_t;

endpackage

// File: hw/fpsu_data_pkg.sv
`include "fpsu_config.svh"

package fpsu_data_pkg;

  // One SIMD half
  typedef logic [`FPSU_HALF_W-1:0] fpsu_half_t;

  // Full operand with lo in the low bits
  typedef struct packed {
    fpsu_half_t hi;
    fpsu_half_t lo;
  } fpsu_pair_t;

  // Operand source is the register value unless fwd is set
  typedef struct packed {
    logic                               fwd;
    logic [$clog2(`FPSU_FWD_SRCS)-1:0]  idx;
  } fpsu_src_sel_t;

  typedef struct packed {
    logic                     en;
    fpsu_op_pkg::fpsu_op_e    op;
    logic [`FPSU_TAG_W-1:0]   tag;
    fpsu_src_sel_t            sel_a;
    fpsu_src_sel_t            sel_b;
  } fpsu_issue_t;

  // A forwarding bus carries both halves
  typedef fpsu_pair_t fpsu_fwd_t;

  // Code is {tag, zero_hi, zero_lo}
  typedef struct packed {
    logic                     en;
    logic [`FPSU_TAG_W+1:0]   code;
  } fpsu_ret_t;

endpackage

// File: hw/fpsu_operand_sel.sv
`timescale 1ns/1ns
`include "fpsu_config.svh"

module fpsu_operand_sel (
  input  fpsu_data_pkg::fpsu_src_sel_t  sel,
  input  fpsu_data_pkg::fpsu_half_t     reg_val,
  input  fpsu_data_pkg::fpsu_half_t     fwd_val [`FPSU_FWD_SRCS],
  output fpsu_data_pkg::fpsu_half_t     operand
);

  import fpsu_data_pkg::*;

  fpsu_half_t fwd_pick;

  // Decode the bus index as a one-hot compare so each source has its own AND term
  always_comb begin
    fwd_pick = '0;
    for (int i = 0; i < `FPSU_FWD_SRCS; i++) begin
      if (sel.idx == i) begin
        fwd_pick = fwd_val[i];
      end
    end
  end

  assign operand = sel.fwd ? fwd_pick : reg_val;

  // A bus index without fwd would point at a bus that is then ignored
  always_comb begin
    if (sel.idx != '0) begin
      a_idx_needs_fwd: assert #0 (sel.fwd)
        else $error("forwarding index %0d given without fwd", sel.idx);
    end
  end

endmodule

// File: hw/fpsu_ctrl.sv
`timescale 1ns/1ns
`include "fpsu_config.svh"

module fpsu_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  fpsu_data_pkg::fpsu_issue_t    issue [`FPSU_NUM_PORTS],
  input  logic                          zero_lo [`FPSU_NUM_PORTS],
  input  logic                          zero_hi [`FPSU_NUM_PORTS],
  output fpsu_op_pkg::fpsu_half_ctrl_t  ctrl_lo [`FPSU_NUM_PORTS],
  output fpsu_op_pkg::fpsu_half_ctrl_t  ctrl_hi [`FPSU_NUM_PORTS],
  output fpsu_data_pkg::fpsu_ret_t      ret [`FPSU_NUM_PORTS]
);

  import fpsu_op_pkg::*;
  import fpsu_data_pkg::*;

  for (genvar p = 0; p < `FPSU_NUM_PORTS; p++) begin : g_port
    fpsu_half_ctrl_t         dec_lo;
    fpsu_half_ctrl_t         dec_hi;
    logic [`FPSU_TAG_W-1:0]  tag_s1;
    logic [`FPSU_TAG_W-1:0]  tag_s2;
    logic                    en_s2;

    always_comb begin
      dec_lo.valid = issue[p].en;
      dec_lo.use_other = 1'b0;
      case (issue[p].op)
        op_and:  dec_lo.func = fn_and;
        op_or:   dec_lo.func = fn_or;
        op_xor:  dec_lo.func = fn_xor;
        op_andn: dec_lo.func = fn_andn;
        default: dec_lo.func = fn_pass;
      endcase
      dec_hi = dec_lo;

      // Cross-half moves take the A operand selected by the other half
      case (issue[p].op)
        op_swap: begin
          dec_lo.use_other = 1'b1;
          dec_hi.use_other = 1'b1;
        end
        op_dup_lo: dec_hi.use_other = 1'b1;
        op_dup_hi: dec_lo.use_other = 1'b1;
        default: ;
      endcase
    end

    // Stage 1 control goes straight to both halves
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        ctrl_lo[p] <= '0;
        ctrl_hi[p] <= '0;
        en_s2 <= 1'b0;
      end else begin
        ctrl_lo[p] <= dec_lo;
        ctrl_hi[p] <= dec_hi;
        en_s2 <= ctrl_lo[p].valid;
      end
    end

    always_ff @(posedge clk) begin
      if (issue[p].en) begin
        tag_s1 <= issue[p].tag;
      end
      if (ctrl_lo[p].valid) begin
        tag_s2 <= tag_s1;
      end
    end

    // Zero flags are registered in the halves at the same edge as en_s2
    assign ret[p] = '{en: en_s2, code: {tag_s2, zero_hi[p], zero_lo[p]}};

    a_ret_after_issue: assert property (
      @(posedge clk) disable iff (!rst_n)
      ret[p].en |-> $past(issue[p].en, 2) &&
                    ret[p].code[`FPSU_TAG_W+1:2] == $past(issue[p].tag, 2)
    ) else $error("port %0d retired without a matching issue two cycles earlier", p);

    // Every 3-bit code is an opcode, so only X or Z can slip past the decode
    a_op_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      issue[p].en |-> !$isunknown(issue[p].op)
    ) else $error("port %0d issued an undefined opcode", p);
  end

endmodule

// File: hw/fpsu_half.sv
`timescale 1ns/1ns
`include "fpsu_config.svh"

module fpsu_half (
  input  logic                          clk,
  input  logic                          rst_n,
  input  fpsu_op_pkg::fpsu_half_ctrl_t  ctrl [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_src_sel_t  sel_a [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_src_sel_t  sel_b [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_half_t     a [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_half_t     b [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_half_t     fwd [`FPSU_FWD_SRCS],
  output fpsu_data_pkg::fpsu_half_t     xa_out [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_half_t     xa_in [`FPSU_NUM_PORTS],
  output fpsu_data_pkg::fpsu_half_t     result [`FPSU_NUM_PORTS],
  output logic                          zero [`FPSU_NUM_PORTS]
);

  import fpsu_op_pkg::*;
  import fpsu_data_pkg::*;

  for (genvar p = 0; p < `FPSU_NUM_PORTS; p++) begin : g_port
    fpsu_half_t sel_a_val;
    fpsu_half_t sel_b_val;
    fpsu_half_t a_q;
    fpsu_half_t b_q;
    fpsu_half_t op_a;
    fpsu_half_t res_d;

    fpsu_operand_sel u_sel_a (
      .sel     (sel_a[p]),
      .reg_val (a[p]),
      .fwd_val (fwd),
      .operand (sel_a_val)
    );

    fpsu_operand_sel u_sel_b (
      .sel     (sel_b[p]),
      .reg_val (b[p]),
      .fwd_val (fwd),
      .operand (sel_b_val)
    );

    // Stage 1 operand registers
    always_ff @(posedge clk) begin
      a_q <= sel_a_val;
      b_q <= sel_b_val;
    end

    // The other half reads our A for swap and dup
    assign xa_out[p] = a_q;

    assign op_a = ctrl[p].use_other ? xa_in[p] : a_q;

    always_comb begin
      case (ctrl[p].func)
        fn_and:  res_d = op_a & b_q;
        fn_or:   res_d = op_a | b_q;
        fn_xor:  res_d = op_a ^ b_q;
        fn_andn: res_d = op_a & ~b_q;
        default: res_d = op_a;
      endcase
    end

    // Result only moves when an operation is in stage 2, so it holds between retires
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        result[p] <= '0;
        zero[p] <= 1'b1;
      end else if (ctrl[p].valid) begin
        result[p] <= res_d;
        zero[p] <= (res_d == '0);
      end
    end
  end

endmodule

// File: hw/fpsu_both.sv
`timescale 1ns/1ns
`include "fpsu_config.svh"

module fpsu_both (
  input  logic                        clk,
  input  logic                        rst_n,
  input  fpsu_data_pkg::fpsu_issue_t  issue [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_pair_t   a [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_pair_t   b [`FPSU_NUM_PORTS],
  input  fpsu_data_pkg::fpsu_fwd_t    fwd [`FPSU_FWD_SRCS],
  output fpsu_data_pkg::fpsu_pair_t   result [`FPSU_NUM_PORTS],
  output fpsu_data_pkg::fpsu_ret_t    ret [`FPSU_NUM_PORTS]
);

  import fpsu_op_pkg::*;
  import fpsu_data_pkg::*;

  fpsu_half_ctrl_t ctrl_lo [`FPSU_NUM_PORTS];
  fpsu_half_ctrl_t ctrl_hi [`FPSU_NUM_PORTS];
  fpsu_src_sel_t   sel_a [`FPSU_NUM_PORTS];
  fpsu_src_sel_t   sel_b [`FPSU_NUM_PORTS];
  fpsu_half_t      a_lo [`FPSU_NUM_PORTS];
  fpsu_half_t      a_hi [`FPSU_NUM_PORTS];
  fpsu_half_t      b_lo [`FPSU_NUM_PORTS];
  fpsu_half_t      b_hi [`FPSU_NUM_PORTS];
  fpsu_half_t      fwd_lo [`FPSU_FWD_SRCS];
  fpsu_half_t      fwd_hi [`FPSU_FWD_SRCS];
  fpsu_half_t      xa_lo [`FPSU_NUM_PORTS];
  fpsu_half_t      xa_hi [`FPSU_NUM_PORTS];
  fpsu_half_t      res_lo [`FPSU_NUM_PORTS];
  fpsu_half_t      res_hi [`FPSU_NUM_PORTS];
  logic            zero_lo [`FPSU_NUM_PORTS];
  logic            zero_hi [`FPSU_NUM_PORTS];

  for (genvar p = 0; p < `FPSU_NUM_PORTS; p++) begin : g_port
    assign sel_a[p] = issue[p].sel_a;
    assign sel_b[p] = issue[p].sel_b;
    assign a_lo[p] = a[p].lo;
    assign a_hi[p] = a[p].hi;
    assign b_lo[p] = b[p].lo;
    assign b_hi[p] = b[p].hi;
    assign result[p] = '{hi: res_hi[p], lo: res_lo[p]};
  end

  for (genvar i = 0; i < `FPSU_FWD_SRCS; i++) begin : g_fwd
    assign fwd_lo[i] = fwd[i].lo;
    assign fwd_hi[i] = fwd[i].hi;
  end

  fpsu_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue),
    .zero_lo (zero_lo),
    .zero_hi (zero_hi),
    .ctrl_lo (ctrl_lo),
    .ctrl_hi (ctrl_hi),
    .ret     (ret)
  );

  // Each half reads the A operand the other half selected
  fpsu_half u_lo (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl_lo),
    .sel_a  (sel_a),
    .sel_b  (sel_b),
    .a      (a_lo),
    .b      (b_lo),
    .fwd    (fwd_lo),
    .xa_out (xa_lo),
    .xa_in  (xa_hi),
    .result (res_lo),
    .zero   (zero_lo)
  );

  fpsu_half u_hi (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl_hi),
    .sel_a  (sel_a),
    .sel_b  (sel_b),
    .a      (a_hi),
    .b      (b_hi),
    .fwd    (fwd_hi),
    .xa_out (xa_hi),
    .xa_in  (xa_lo),
    .result (res_hi),
    .zero   (zero_hi)
  );

endmodule

// File: bench/fpsu_tb.sv
`timescale 1ns/1ns
`include "fpsu_config.svh"

module fpsu_tb;

  import fpsu_op_pkg::*;
  import fpsu_data_pkg::*;

  // One line of the vector file
  typedef struct packed {
    logic [7:0]                        port;
    fpsu_op_e                          op;
    logic [`FPSU_TAG_W-1:0]            tag;
    fpsu_src_sel_t                     sel_a;
    fpsu_src_sel_t                     sel_b;
    fpsu_pair_t                        a;
    fpsu_pair_t                        b;
    fpsu_pair_t [`FPSU_FWD_SRCS-1:0]   fwd;
    fpsu_pair_t                        res;
    fpsu_ret_t                         ret;
  } vec_t;

  // An operation in flight and the negedge count at which it must retire
  typedef struct packed {
    logic [7:0]  port;
    logic [31:0] due;
    logic [15:0] vidx;
  } expect_t;

  logic        clk;
  logic        rst_n;
  fpsu_issue_t issue [`FPSU_NUM_PORTS];
  fpsu_pair_t  a [`FPSU_NUM_PORTS];
  fpsu_pair_t  b [`FPSU_NUM_PORTS];
  fpsu_fwd_t   fwd [`FPSU_FWD_SRCS];
  fpsu_pair_t  result [`FPSU_NUM_PORTS];
  fpsu_ret_t   ret [`FPSU_NUM_PORTS];

  vec_t    vecs[$];
  string   names[$];
  expect_t exp_q[$];
  int      n_vec = 0;
  int      cyc_cnt = 0;

  fpsu_both uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .a      (a),
    .b      (b),
    .fwd    (fwd),
    .result (result),
    .ret    (ret)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input fpsu_pair_t exp_val,
                              input fpsu_pair_t act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("MISMATCH %s result: expected hi=%h lo=%h, actual hi=%h lo=%h",
                          name, exp_val.hi, exp_val.lo, act_val.hi, act_val.lo));
    end
  endtask

  task automatic check_ret(input string name, input fpsu_ret_t exp_val,
                           input fpsu_ret_t act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("MISMATCH %s retire: expected en=%b code=%h, actual en=%b code=%h",
                          name, exp_val.en, exp_val.code, act_val.en, act_val.code));
    end
  endtask

  task automatic load_vectors();
    int         fd;
    int         cnt;
    int         port, op, tag, af, ai, bf, bi;
    string      line;
    string      nm;
    fpsu_half_t a_hi, a_lo, b_hi, b_lo;
    fpsu_half_t f0h, f0l, f1h, f1l, f2h, f2l, f3h, f3l;
    fpsu_half_t e_lo, e_hi;
    logic [7:0] code;
    vec_t       v;
    fd = $fopen("bench/fpsu_tb_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file bench/fpsu_tb_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line,
          "%s %d %d %d %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          nm, port, op, tag, af, ai, bf, bi, a_hi, a_lo, b_hi, b_lo,
          f0h, f0l, f1h, f1l, f2h, f2l, f3h, f3l, e_lo, e_hi, code);
        if (cnt != 23 || port >= `FPSU_NUM_PORTS) begin
          abort_run($sformatf("vector line could not be read: %s", line));
        end
        v.port = port[7:0];
        v.op = fpsu_op_e'(op[2:0]);
        v.tag = tag[`FPSU_TAG_W-1:0];
        v.sel_a.fwd = af[0];
        v.sel_a.idx = ai[1:0];
        v.sel_b.fwd = bf[0];
        v.sel_b.idx = bi[1:0];
        v.a = '{hi: a_hi, lo: a_lo};
        v.b = '{hi: b_hi, lo: b_lo};
        v.fwd[0] = '{hi: f0h, lo: f0l};
        v.fwd[1] = '{hi: f1h, lo: f1l};
        v.fwd[2] = '{hi: f2h, lo: f2l};
        v.fwd[3] = '{hi: f3h, lo: f3l};
        v.res = '{hi: e_hi, lo: e_lo};
        v.ret = '{en: 1'b1, code: code};
        vecs.push_back(v);
        names.push_back(nm);
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_vector(input int k);
    vec_t        v;
    fpsu_issue_t iss;
    expect_t     e;
    v = vecs[k];
    iss.en = 1'b1;
    iss.op = v.op;
    iss.tag = v.tag;
    iss.sel_a = v.sel_a;
    iss.sel_b = v.sel_b;
    issue[v.port] <= iss;
    a[v.port] <= v.a;
    b[v.port] <= v.b;
    for (int i = 0; i < `FPSU_FWD_SRCS; i++) begin
      fwd[i] <= v.fwd[i];
    end
    e.port = v.port;
    e.due = cyc_cnt + 2;
    e.vidx = k[15:0];
    exp_q.push_back(e);
  endtask

  // A port 0 line followed by a port 1 line issues on both ports in one cycle
  task automatic run_vectors();
    int i;
    int idle_left;
    i = 0;
    idle_left = 8;
    while (i < vecs.size()) begin
      @(posedge clk);
      for (int p = 0; p < `FPSU_NUM_PORTS; p++) begin
        issue[p] <= '0;
      end
      if (idle_left > 0 && ($urandom % 4) == 0) begin
        idle_left--;
      end else if (i + 1 < vecs.size() && vecs[i].port == 0 && vecs[i + 1].port == 1) begin
        if (vecs[i + 1].fwd != vecs[i].fwd) begin
          abort_run($sformatf("paired lines %s and %s disagree on the forwarding buses",
                              names[i], names[i + 1]));
        end
        issue_vector(i);
        issue_vector(i + 1);
        i += 2;
      end else begin
        issue_vector(i);
        i += 1;
      end
    end
    @(posedge clk);
    for (int p = 0; p < `FPSU_NUM_PORTS; p++) begin
      issue[p] <= '0;
    end
  endtask

  task automatic retire_check(input int p);
    int      found;
    expect_t e;
    vec_t    v;
    found = -1;
    for (int k = 0; k < exp_q.size() && found < 0; k++) begin
      if (exp_q[k].port == p) begin
        found = k;
      end
    end
    if (found < 0) begin
      abort_run($sformatf("port %0d raised a retire pulse with no operation in flight", p));
    end else begin
      e = exp_q[found];
      v = vecs[e.vidx];
      if (cyc_cnt != e.due) begin
        abort_run($sformatf("test %s on port %0d retired at cycle %0d instead of cycle %0d",
                            names[e.vidx], p, cyc_cnt, e.due));
      end
      check_result(names[e.vidx], v.res, result[p]);
      check_ret(names[e.vidx], v.ret, ret[p]);
      exp_q.delete(found);
    end
  endtask

  // Outputs settle after the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < `FPSU_NUM_PORTS; p++) begin
        if ($isunknown(ret[p].en)) begin
          abort_run($sformatf("retire enable of port %0d is unknown after reset", p));
        end else if (ret[p].en) begin
          retire_check(p);
        end
      end
    end
    cyc_cnt = cyc_cnt + 1;
  end

  initial begin
    wait (n_vec > 0);
    #((n_vec + 20) * 4);
    abort_run($sformatf("timeout: the run did not end within %0d ns", (n_vec + 20) * 4));
  end

  initial begin
    void'($urandom(32'h278e61ff));
    rst_n = 1'b0;
    for (int p = 0; p < `FPSU_NUM_PORTS; p++) begin
      issue[p] = '0;
      a[p] = '0;
      b[p] = '0;
    end
    for (int i = 0; i < `FPSU_FWD_SRCS; i++) begin
      fwd[i] = '0;
    end
    load_vectors();
    if (vecs.size() == 0) begin
      abort_run("no vectors were found in bench/fpsu_tb_input.txt");
    end
    n_vec = vecs.size();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet cycles where any retire pulse is a failure
    repeat (2) @(posedge clk);
    run_vectors();
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d operations never retired", exp_q.size()));
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+hw
hw/fpsu_op_pkg.sv
hw/fpsu_data_pkg.sv
hw/fpsu_operand_sel.sv
hw/fpsu_ctrl.sv
hw/fpsu_half.sv
hw/fpsu_both.sv
bench/fpsu_tb.sv

// File: bench/fpsu_tb_input.txt
# name port op tag a_fwd a_idx b_fwd b_idx a_hi a_lo b_hi b_lo, then fwd0..fwd3 as hi lo,
# then exp_lo exp_hi exp_code; values and code in hex, the other fields in decimal
# op 0 and 1 or 2 xor 3 andn 4 mov 5 swap 6 dup_lo 7 dup_hi; code is {tag, zero_hi, zero_lo}
and_p0 0 0 1 0 0 0 0 ff00 0f0f f0f0 00ff a0 0a b1 1b c2 2c d3 3d 000f f000 04
and_wide_p1 1 0 2 0 0 0 0 fffffffffffffffff 123456789abcdef01 80000000000000001 fffffffff00000000 a0 0a b1 1b c2 2c d3 3d 12345678900000000 80000000000000001 08
or_p0 0 1 3 0 0 0 0 1 0 2 0 a0 0a b1 1b c2 2c d3 3d 0 3 0d
or_wide_p1 1 1 4 0 0 0 0 f0000000000000000 5 f a a0 0a b1 1b c2 2c d3 3d f f000000000000000f 10
xor_p0 0 2 5 0 0 0 0 ffff abcd ffff 1234 a0 0a b1 1b c2 2c d3 3d b9f9 0 16
xor_wide_p1 1 2 6 0 0 0 0 aaaaaaaaaaaaaaaaa 0 55555555555555555 0 a0 0a b1 1b c2 2c d3 3d 0 fffffffffffffffff 19
andn_p0 0 3 7 0 0 0 0 ff ff 0f f0 a0 0a b1 1b c2 2c d3 3d 0f f0 1c
andn_wide_p1 1 3 8 0 0 0 0 fffffffffffffffff 1234 fffffffffffffffff 0 a0 0a b1 1b c2 2c d3 3d 1234 0 22
mov_p0 0 4 9 0 0 0 0 cafe beef 1 1 a0 0a b1 1b c2 2c d3 3d beef cafe 24
mov_zero_p1 1 4 10 0 0 0 0 0 0 ffff ffff a0 0a b1 1b c2 2c d3 3d 0 0 2b
and_zero_p0 0 0 11 0 0 0 0 f0 0f 0f f0 a0 0a b1 1b c2 2c d3 3d 0 0 2f
or_cross_p1 1 1 12 0 0 0 0 80000000000000000 1 1 80000000000000000 a0 0a b1 1b c2 2c d3 3d 80000000000000001 80000000000000001 30
fwd_a0_p0 0 4 13 1 0 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 0a a0 34
fwd_a1_p1 1 4 14 1 1 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 1b b1 38
fwd_a2_p0 0 4 15 1 2 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 2c c2 3c
fwd_a3_p1 1 4 16 1 3 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 3d d3 40
fwd_b0_p0 0 1 17 0 0 1 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 600a 50a0 44
fwd_b1_p1 1 1 18 0 0 1 1 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 601b 50b1 48
fwd_b2_p0 0 2 19 0 0 1 2 c2 2c 7000 8000 a0 0a b1 1b c2 2c d3 3d 0 0 4f
fwd_b3_p1 1 2 20 0 0 1 3 d3 3c 7000 8000 a0 0a b1 1b c2 2c d3 3d 01 0 52
fwd_ab_p0 0 1 21 1 1 1 2 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 3f f3 54
fwd_ab_p1 1 3 22 1 3 1 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 35 53 58
fwd_same_p0 0 0 23 1 2 1 2 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 2c c2 5c
fwd_same_p1 1 2 24 1 1 1 1 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 0 0 63
fwd_wide_p1 1 2 25 1 3 0 0 1 1 0f0f0f0f0f0f0f0f0 55555555555555555 0 0 0 0 0 0 fffffffffffffffff aaaaaaaaaaaaaaaaa fffffffffffffffff f0f0f0f0f0f0f0f0f 64
swap_p0 0 5 26 0 0 0 0 1111 2222 3 3 a0 0a b1 1b c2 2c d3 3d 1111 2222 68
swap_wide_p1 1 5 27 0 0 0 0 fffffffffffffffff 0 3 3 a0 0a b1 1b c2 2c d3 3d fffffffffffffffff 0 6e
duplo_p0 0 6 28 0 0 0 0 abc def 3 3 a0 0a b1 1b c2 2c d3 3d def def 70
duplo_zero_p1 1 6 29 0 0 0 0 5 0 3 3 a0 0a b1 1b c2 2c d3 3d 0 0 77
duphi_p0 0 7 30 0 0 0 0 abc def 3 3 a0 0a b1 1b c2 2c d3 3d abc abc 78
duphi_wide_p1 1 7 31 0 0 0 0 12345678912345678 0 3 3 a0 0a b1 1b c2 2c d3 3d 12345678912345678 12345678912345678 7c
swap_fwd_p0 0 5 32 1 2 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d c2 2c 80
duplo_fwd_p1 1 6 33 1 1 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 1b 1b 84
duphi_fwd_p0 0 7 34 1 3 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d d3 d3 88
swap_fwd_p1 1 5 35 1 0 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d a0 0a 8c
b2b_a_p0 0 2 36 0 0 0 0 f f0 1 10 a0 0a b1 1b c2 2c d3 3d e0 e 90
b2b_b_p0 0 1 37 0 0 0 0 100 0 0 0 a0 0a b1 1b c2 2c d3 3d 0 100 95
b2b_c_p0 0 4 38 0 0 0 0 0 77 0 0 a0 0a b1 1b c2 2c d3 3d 77 0 9a
b2b_d_p1 1 0 39 0 0 0 0 fffff 3 0ffff 1 a0 0a b1 1b c2 2c d3 3d 1 ffff 9c
b2b_e_p1 1 3 40 0 0 0 0 7 7 7 0 a0 0a b1 1b c2 2c d3 3d 7 0 a2
b2b_f_p1 1 7 41 0 0 0 0 9 8 0 0 a0 0a b1 1b c2 2c d3 3d 9 9 a4
b2b_g_p0 0 6 42 1 0 0 0 5000 6000 7000 8000 a0 0a b1 1b c2 2c d3 3d 0a 0a a8
b2b_h_p1 1 5 43 0 0 0 0 1 2 0 0 a0 0a b1 1b c2 2c d3 3d 1 2 ac
tag_max_p0 0 0 63 0 0 0 0 0 0 0 0 a0 0a b1 1b c2 2c d3 3d 0 0 ff
tag_max_p1 1 1 62 0 0 0 0 1 1 0 0 a0 0a b1 1b c2 2c d3 3d 1 1 f8
